/* hw/usb_ep_pkg.sv */
`default_nettype none

package usb_ep_pkg;

    // Non-control endpoints per direction, index 0 maps to endpoint 1
    localparam int EP_COUNT = 3;

    // Bytes held by each endpoint buffer
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

    // Largest payload sent to the host in one packet
    localparam int MAX_PACKET = 8;

    typedef logic [7:0] byte_t;

    // Endpoint number as seen on the bus, 0 is the control endpoint
    typedef logic [1:0] ep_num_t;

    typedef logic [EP_COUNT-1:0] ep_mask_t;

    // Buffer pointer with one extra wrap bit
    typedef logic [FIFO_ADDR_W:0] fifo_ptr_t;

    // Counts bytes of one transmitted packet, 0 to MAX_PACKET
    typedef logic [$clog2(MAX_PACKET):0] pkt_cnt_t;

    typedef enum logic [1:0] {TX_IDLE, TX_SEND, TX_WAIT_HS} tx_state_t;

endpackage

`default_nettype wire

/* hw/ep_fifo_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface ep_fifo_if;
    import usb_ep_pkg::*;

    // Write side, driven by whoever fills the buffer
    logic  push;
    byte_t push_data;
    logic  push_done;
    logic  push_ok;
    logic  full;

    // Read side, driven by whoever drains the buffer
    logic  pop;
    logic  pop_done;
    logic  pop_ok;
    logic  avail;
    byte_t pop_data;

    modport producer (
        output push, push_data, push_done, push_ok,
        input  full
    );

    modport consumer (
        output pop, pop_done, pop_ok,
        input  avail, pop_data
    );

    // The buffer itself sits on the receiving end of both sides
    modport prod_tgt (
        input  push, push_data, push_done, push_ok,
        output full
    );

    modport cons_tgt (
        input  pop, pop_done, pop_ok,
        output avail, pop_data
    );

endinterface

`default_nettype wire

/* hw/ep_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module ep_fifo (
    input  logic        clk48_i,
    input  logic        rst_i,
    ep_fifo_if.prod_tgt prod,
    ep_fifo_if.cons_tgt cons
);
    import usb_ep_pkg::*;

    byte_t     mem [FIFO_DEPTH];

    // Each side keeps a committed pointer and a tentative one that runs ahead
    fifo_ptr_t wr_commit;
    fifo_ptr_t wr_tent;
    fifo_ptr_t rd_commit;
    fifo_ptr_t rd_tent;

    fifo_ptr_t wr_tent_nxt;
    fifo_ptr_t rd_tent_nxt;
    fifo_ptr_t used;
    logic      push_acc;
    logic      pop_acc;

    // Space is only freed by committed reads, while tentative writes already claim it
    assign used      = wr_tent - rd_commit;
    assign prod.full = (used == fifo_ptr_t'(FIFO_DEPTH));

    // The reader only ever sees data behind the committed write pointer
    assign cons.avail    = (wr_commit != rd_tent);
    assign cons.pop_data = mem[rd_tent[FIFO_ADDR_W-1:0]];

    assign push_acc = prod.push && !prod.full;
    assign pop_acc  = cons.pop && cons.avail;

    assign wr_tent_nxt = wr_tent + fifo_ptr_t'(push_acc);
    assign rd_tent_nxt = rd_tent + fifo_ptr_t'(pop_acc);

    always_ff @(posedge clk48_i) begin
        if (push_acc) begin
            mem[wr_tent[FIFO_ADDR_W-1:0]] <= prod.push_data;
        end
    end

    // Write transaction
    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            wr_commit <= '0;
            wr_tent   <= '0;
        end else if (prod.push_done) begin
            if (prod.push_ok) begin
                // A byte pushed together with the done strobe belongs to the transaction
                wr_commit <= wr_tent_nxt;
                wr_tent   <= wr_tent_nxt;
            end else begin
                wr_tent <= wr_commit;
            end
        end else begin
            wr_tent <= wr_tent_nxt;
        end
    end

    // Read transaction
    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            rd_commit <= '0;
            rd_tent   <= '0;
        end else if (cons.pop_done) begin
            if (cons.pop_ok) begin
                rd_commit <= rd_tent_nxt;
                rd_tent   <= rd_tent_nxt;
            end else begin
                // Rolled back bytes become readable again from the committed head
                rd_tent <= rd_commit;
            end
        end else begin
            rd_tent <= rd_tent_nxt;
        end
    end

    // The producer must respect full, whichever block drives it
    a_no_push_full: assert property (
        @(posedge clk48_i) disable iff (rst_i)
        prod.push |-> !prod.full
    ) else $error("push into a full endpoint buffer");

    a_no_pop_empty: assert property (
        @(posedge clk48_i) disable iff (rst_i)
        cons.pop |-> cons.avail
    ) else $error("pop from an endpoint buffer without available data");

    // Commits and rollbacks on both sides must never push the fill level past the depth
    a_occupancy: assert property (
        @(posedge clk48_i) disable iff (rst_i)
        used <= fifo_ptr_t'(FIFO_DEPTH)
    ) else $error("endpoint buffer occupancy above depth");

endmodule

`default_nettype wire

/* hw/ep_rx_router.sv */
`timescale 1ns/10ps
`default_nettype none

module ep_rx_router (
    input  logic                clk48_i,
    input  logic                rst_i,
    input  usb_ep_pkg::ep_num_t rx_ep_i,
    input  logic                rx_valid_i,
    input  usb_ep_pkg::byte_t   rx_data_i,
    input  logic                rx_end_i,
    input  logic                rx_crc_ok_i,
    output logic                rx_ack_o,
    output logic                rx_nak_o,
    ep_fifo_if.producer         ep [usb_ep_pkg::EP_COUNT]
);
    import usb_ep_pkg::*;

    ep_mask_t sel;
    ep_mask_t full_vec;
    logic     hit_full;
    logic     dropped;
    logic     accept;

    // Endpoint 0 selects no buffer at all
    always_comb begin
        for (int k = 0; k < EP_COUNT; k++) begin
            sel[k] = (rx_ep_i == ep_num_t'(k + 1));
        end
    end

    for (genvar k = 0; k < EP_COUNT; k++) begin : g_ep
        assign full_vec[k] = ep[k].full;

        // Bytes that do not fit are not forwarded, the packet is refused instead
        assign ep[k].push      = rx_valid_i && sel[k] && !ep[k].full;
        assign ep[k].push_data = rx_data_i;

        // The packet end closes the write transaction of the addressed buffer only
        assign ep[k].push_done = rx_end_i && sel[k];
        assign ep[k].push_ok   = accept;
    end

    assign hit_full = rx_valid_i && |(sel & full_vec);

    // Only meaningful in the rx_end_i cycle, where rx_crc_ok_i is valid
    assign accept = |sel && rx_crc_ok_i && !dropped;

    // Sticky over one packet, so a late drop still refuses the whole packet
    always_ff @(posedge clk48_i) begin
        if (rst_i || rx_end_i) begin
            dropped <= 1'b0;
        end else if (hit_full) begin
            dropped <= 1'b1;
        end
    end

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            rx_ack_o <= 1'b0;
            rx_nak_o <= 1'b0;
        end else begin
            rx_ack_o <= rx_end_i && accept;
            rx_nak_o <= rx_end_i && !accept;
        end
    end

    // The packet engine reports the end strictly after the last payload byte
    a_end_after_data: assert property (
        @(posedge clk48_i) disable iff (rst_i)
        !(rx_valid_i && rx_end_i)
    ) else $error("rx_valid_i and rx_end_i high in the same cycle");

endmodule

`default_nettype wire

/* hw/ep_tx_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module ep_tx_sequencer (
    input  logic                clk48_i,
    input  logic                rst_i,
    input  logic                tx_req_i,
    input  usb_ep_pkg::ep_num_t tx_ep_i,
    input  logic                tx_ack_i,
    input  logic                tx_fail_i,
    output logic                tx_valid_o,
    output usb_ep_pkg::byte_t   tx_data_o,
    output logic                tx_last_o,
    output logic                tx_nak_o,
    ep_fifo_if.consumer         ep [usb_ep_pkg::EP_COUNT]
);
    import usb_ep_pkg::*;

    tx_state_t state;
    ep_mask_t  req_sel;
    ep_mask_t  cur_sel;
    ep_mask_t  src_sel;
    ep_mask_t  avail_vec;
    byte_t     data_vec [EP_COUNT];
    byte_t     head_byte;
    byte_t     data_q;
    pkt_cnt_t  byte_cnt;
    logic      start;
    logic      more;
    logic      hs;

    for (genvar k = 0; k < EP_COUNT; k++) begin : g_ep
        assign avail_vec[k] = ep[k].avail;
        assign data_vec[k]  = ep[k].pop_data;

        // The first byte is popped in the request cycle, the rest one per cycle in TX_SEND
        assign ep[k].pop      = (start && req_sel[k]) || (more && cur_sel[k]);
        assign ep[k].pop_done = hs && cur_sel[k];
        assign ep[k].pop_ok   = tx_ack_i;
    end

    always_comb begin
        for (int k = 0; k < EP_COUNT; k++) begin
            req_sel[k] = (tx_ep_i == ep_num_t'(k + 1));
        end
    end

    // Requests outside TX_IDLE never start anything
    assign start = (state == TX_IDLE) && tx_req_i && |(req_sel & avail_vec);

    // avail already reflects every byte popped so far, so it tells whether one is left
    assign more = (state == TX_SEND) && |(cur_sel & avail_vec)
                  && (byte_cnt != pkt_cnt_t'(MAX_PACKET));

    assign hs = (state == TX_WAIT_HS) && (tx_ack_i || tx_fail_i);

    assign src_sel = (state == TX_IDLE) ? req_sel : cur_sel;

    always_comb begin
        head_byte = '0;
        for (int k = 0; k < EP_COUNT; k++) begin
            if (src_sel[k]) begin
                head_byte = data_vec[k];
            end
        end
    end

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            state    <= TX_IDLE;
            cur_sel  <= '0;
            byte_cnt <= '0;
            tx_nak_o <= 1'b0;
        end else begin
            // Invalid endpoint or nothing committed gives a nak in the next cycle
            tx_nak_o <= (state == TX_IDLE) && tx_req_i && !start;
            case (state)
                TX_IDLE: begin
                    if (start) begin
                        state    <= TX_SEND;
                        cur_sel  <= req_sel;
                        byte_cnt <= pkt_cnt_t'(1);
                    end
                end
                TX_SEND: begin
                    if (more) begin
                        byte_cnt <= byte_cnt + pkt_cnt_t'(1);
                    end else begin
                        state <= TX_WAIT_HS;
                    end
                end
                TX_WAIT_HS: begin
                    // No timeout, the host answer always comes from the bus side
                    if (hs) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk48_i) begin
        if (start || more) begin
            data_q <= head_byte;
        end
    end

    assign tx_valid_o = (state == TX_SEND);
    assign tx_data_o  = data_q;
    assign tx_last_o  = (state == TX_SEND) && !more;

    a_hs_in_wait: assert property (
        @(posedge clk48_i) disable iff (rst_i)
        (tx_ack_i || tx_fail_i) |-> (state == TX_WAIT_HS)
    ) else $error("host handshake outside TX_WAIT_HS");

    a_hs_exclusive: assert property (
        @(posedge clk48_i) disable iff (rst_i)
        !(tx_ack_i && tx_fail_i)
    ) else $error("tx_ack_i and tx_fail_i high together");

endmodule

`default_nettype wire

/* hw/usb_ep_top.sv */
`timescale 1ns/10ps
`default_nettype none

// Endpoint names are device centric: in endpoints receive from the host.
// Index 0 is endpoint 1, the control endpoint has no user access.
module usb_ep_top (
    input  logic                                clk48_i,
    input  logic                                rst_i,

    // Received packet payload
    input  usb_ep_pkg::ep_num_t                 rx_ep_i,
    input  logic                                rx_valid_i,
    input  usb_ep_pkg::byte_t                   rx_data_i,
    input  logic                                rx_end_i,
    input  logic                                rx_crc_ok_i,
    output logic                                rx_ack_o,
    output logic                                rx_nak_o,

    // Transmitted packet payload
    input  logic                                tx_req_i,
    input  usb_ep_pkg::ep_num_t                 tx_ep_i,
    input  logic                                tx_ack_i,
    input  logic                                tx_fail_i,
    output logic                                tx_valid_o,
    output usb_ep_pkg::byte_t                   tx_data_o,
    output logic                                tx_last_o,
    output logic                                tx_nak_o,

    // User side of the in endpoints
    input  usb_ep_pkg::ep_mask_t                ep_in_pop_data_i,
    input  usb_ep_pkg::ep_mask_t                ep_in_pop_trans_done_i,
    input  usb_ep_pkg::ep_mask_t                ep_in_pop_trans_success_i,
    output usb_ep_pkg::ep_mask_t                ep_in_data_available_o,
    output logic [8*usb_ep_pkg::EP_COUNT-1:0]   ep_in_data_o,

    // User side of the out endpoints
    input  usb_ep_pkg::ep_mask_t                ep_out_data_valid_i,
    input  usb_ep_pkg::ep_mask_t                ep_out_fill_trans_done_i,
    input  usb_ep_pkg::ep_mask_t                ep_out_fill_trans_success_i,
    output usb_ep_pkg::ep_mask_t                ep_out_full_o,
    input  logic [8*usb_ep_pkg::EP_COUNT-1:0]   ep_out_data_i
);
    import usb_ep_pkg::*;

    ep_fifo_if in_if [EP_COUNT] ();
    ep_fifo_if out_if [EP_COUNT] ();

    for (genvar k = 0; k < EP_COUNT; k++) begin : g_in
        ep_fifo u_in_fifo (
            .clk48_i (clk48_i),
            .rst_i   (rst_i),
            .prod    (in_if[k]),
            .cons    (in_if[k])
        );

        // The application drains in endpoints directly
        assign in_if[k].pop              = ep_in_pop_data_i[k];
        assign in_if[k].pop_done         = ep_in_pop_trans_done_i[k];
        assign in_if[k].pop_ok           = ep_in_pop_trans_success_i[k];
        assign ep_in_data_available_o[k] = in_if[k].avail;
        assign ep_in_data_o[8*k +: 8]    = in_if[k].pop_data;
    end

    for (genvar k = 0; k < EP_COUNT; k++) begin : g_out
        ep_fifo u_out_fifo (
            .clk48_i (clk48_i),
            .rst_i   (rst_i),
            .prod    (out_if[k]),
            .cons    (out_if[k])
        );

        // The application fills out endpoints directly
        assign out_if[k].push      = ep_out_data_valid_i[k];
        assign out_if[k].push_data = ep_out_data_i[8*k +: 8];
        assign out_if[k].push_done = ep_out_fill_trans_done_i[k];
        assign out_if[k].push_ok   = ep_out_fill_trans_success_i[k];
        assign ep_out_full_o[k]    = out_if[k].full;
    end

    ep_rx_router u_rx_router (
        .clk48_i     (clk48_i),
        .rst_i       (rst_i),
        .rx_ep_i     (rx_ep_i),
        .rx_valid_i  (rx_valid_i),
        .rx_data_i   (rx_data_i),
        .rx_end_i    (rx_end_i),
        .rx_crc_ok_i (rx_crc_ok_i),
        .rx_ack_o    (rx_ack_o),
        .rx_nak_o    (rx_nak_o),
        .ep          (in_if)
    );

    ep_tx_sequencer u_tx_sequencer (
        .clk48_i    (clk48_i),
        .rst_i      (rst_i),
        .tx_req_i   (tx_req_i),
        .tx_ep_i    (tx_ep_i),
        .tx_ack_i   (tx_ack_i),
        .tx_fail_i  (tx_fail_i),
        .tx_valid_o (tx_valid_o),
        .tx_data_o  (tx_data_o),
        .tx_last_o  (tx_last_o),
        .tx_nak_o   (tx_nak_o),
        .ep         (out_if)
    );

endmodule

`default_nettype wire

/* test/tb_usb_ep_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_usb_ep_top;
    import usb_ep_pkg::*;

    localparam int CYCLE_LIMIT = 4000;

    logic        clk48_i;
    logic        rst_i;
    ep_num_t     rx_ep_i;
    logic        rx_valid_i;
    byte_t       rx_data_i;
    logic        rx_end_i;
    logic        rx_crc_ok_i;
    logic        rx_ack_o;
    logic        rx_nak_o;
    logic        tx_req_i;
    ep_num_t     tx_ep_i;
    logic        tx_ack_i;
    logic        tx_fail_i;
    logic        tx_valid_o;
    byte_t       tx_data_o;
    logic        tx_last_o;
    logic        tx_nak_o;
    ep_mask_t    ep_in_pop_data_i;
    ep_mask_t    ep_in_pop_trans_done_i;
    ep_mask_t    ep_in_pop_trans_success_i;
    ep_mask_t    ep_in_data_available_o;
    logic [8*EP_COUNT-1:0] ep_in_data_o;
    ep_mask_t    ep_out_data_valid_i;
    ep_mask_t    ep_out_fill_trans_done_i;
    ep_mask_t    ep_out_fill_trans_success_i;
    ep_mask_t    ep_out_full_o;
    logic [8*EP_COUNT-1:0] ep_out_data_i;

    // Reference model: committed bytes, pending writes and tentative read counts
    byte_t       in_q [EP_COUNT][$];
    byte_t       in_pend [EP_COUNT][$];
    int          in_rd [EP_COUNT];
    byte_t       out_q [EP_COUNT][$];
    byte_t       out_pend [EP_COUNT][$];
    logic        rx_drop;
    logic        tx_busy;
    int          tx_k;
    int          tx_idx;
    int          tx_left;

    // Expected outputs for the cycle that follows each model update
    ep_mask_t    exp_in_avail;
    byte_t       exp_in_data [EP_COUNT];
    ep_mask_t    exp_out_full;
    logic        exp_rx_ack;
    logic        exp_rx_nak;
    logic        exp_tx_valid;
    logic        exp_tx_last;
    logic        exp_tx_nak;
    byte_t       exp_tx_data;

    logic [7:0]  lfsr_q;
    int          error_cnt;
    int          trans_cnt;
    int          cycle_cnt;

    usb_ep_top u_usb_ep_top (.*);

    initial begin
        clk48_i = 1'b0;
        forever #5 clk48_i = ~clk48_i;
    end

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // One LFSR step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = (v << 1) | int'(lfsr_q[0]);
        end
        return v;
    endfunction

    task automatic flag_error(input string msg);
        error_cnt++;
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    always @(posedge clk48_i) begin
        int  k;
        logic acc;
        if (rst_i) begin
            for (k = 0; k < EP_COUNT; k++) begin
                in_q[k].delete();
                in_pend[k].delete();
                in_rd[k] = 0;
                out_q[k].delete();
                out_pend[k].delete();
            end
            rx_drop    = 1'b0;
            tx_busy    = 1'b0;
            tx_k       = 0;
            tx_idx     = 0;
            tx_left    = 0;
            exp_rx_ack = 1'b0;
            exp_rx_nak = 1'b0;
            exp_tx_nak = 1'b0;
        end else begin
            // Bus receive: bytes that do not fit mark the packet as dropped
            exp_rx_ack = 1'b0;
            exp_rx_nak = 1'b0;
            if (rx_valid_i && rx_ep_i != 0) begin
                k = int'(rx_ep_i) - 1;
                if (in_q[k].size() + in_pend[k].size() < FIFO_DEPTH) begin
                    in_pend[k].push_back(rx_data_i);
                end else begin
                    rx_drop = 1'b1;
                end
            end
            if (rx_end_i) begin
                acc = (rx_ep_i != 0) && rx_crc_ok_i && !rx_drop;
                exp_rx_ack = acc;
                exp_rx_nak = !acc;
                if (rx_ep_i != 0) begin
                    k = int'(rx_ep_i) - 1;
                    if (acc) begin
                        for (int i = 0; i < in_pend[k].size(); i++) begin
                            in_q[k].push_back(in_pend[k][i]);
                        end
                    end
                    in_pend[k].delete();
                end
                rx_drop = 1'b0;
            end
            // User side of both directions
            for (k = 0; k < EP_COUNT; k++) begin
                if (ep_in_pop_data_i[k] && in_rd[k] < in_q[k].size()) begin
                    in_rd[k]++;
                end
                if (ep_in_pop_trans_done_i[k]) begin
                    if (ep_in_pop_trans_success_i[k]) begin
                        repeat (in_rd[k]) void'(in_q[k].pop_front());
                    end
                    in_rd[k] = 0;
                end
                if (ep_out_data_valid_i[k]
                    && out_q[k].size() + out_pend[k].size() < FIFO_DEPTH) begin
                    out_pend[k].push_back(ep_out_data_i[8*k +: 8]);
                end
                if (ep_out_fill_trans_done_i[k]) begin
                    if (ep_out_fill_trans_success_i[k]) begin
                        for (int i = 0; i < out_pend[k].size(); i++) begin
                            out_q[k].push_back(out_pend[k][i]);
                        end
                    end
                    out_pend[k].delete();
                end
            end
            // Bus transmit: bytes leave the model queue only on the host's ack
            exp_tx_nak = 1'b0;
            if (tx_left > 0) begin
                tx_idx++;
                tx_left--;
            end
            if (tx_busy && (tx_ack_i || tx_fail_i)) begin
                if (tx_ack_i) begin
                    repeat (tx_idx) void'(out_q[tx_k].pop_front());
                end
                tx_busy = 1'b0;
            end else if (!tx_busy && tx_req_i) begin
                if (tx_ep_i != 0 && out_q[int'(tx_ep_i) - 1].size() > 0) begin
                    tx_busy = 1'b1;
                    tx_k    = int'(tx_ep_i) - 1;
                    tx_idx  = 0;
                    tx_left = (out_q[tx_k].size() < MAX_PACKET) ? out_q[tx_k].size()
                                                                : MAX_PACKET;
                end else begin
                    exp_tx_nak = 1'b1;
                end
            end
        end
        for (k = 0; k < EP_COUNT; k++) begin
            exp_in_avail[k] = (in_rd[k] < in_q[k].size());
            exp_in_data[k]  = exp_in_avail[k] ? in_q[k][in_rd[k]] : '0;
            exp_out_full[k] = (out_q[k].size() + out_pend[k].size() == FIFO_DEPTH);
        end
        exp_tx_valid = (tx_left > 0);
        exp_tx_last  = (tx_left == 1);
        exp_tx_data  = (tx_left > 0) ? out_q[tx_k][tx_idx] : '0;
    end

    for (genvar k = 0; k < EP_COUNT; k++) begin : g_chk
        a_in_avail: assert property (@(posedge clk48_i) disable iff (rst_i)
            ep_in_data_available_o[k] == exp_in_avail[k])
            else flag_error($sformatf("in endpoint %0d availability", k + 1));
        a_in_data: assert property (@(posedge clk48_i) disable iff (rst_i)
            exp_in_avail[k] |-> ep_in_data_o[8*k +: 8] == exp_in_data[k])
            else flag_error($sformatf("in endpoint %0d head byte", k + 1));
        a_out_full: assert property (@(posedge clk48_i) disable iff (rst_i)
            ep_out_full_o[k] == exp_out_full[k])
            else flag_error($sformatf("out endpoint %0d full flag", k + 1));
    end

    a_rx_resp: assert property (@(posedge clk48_i) disable iff (rst_i)
        rx_ack_o == exp_rx_ack && rx_nak_o == exp_rx_nak)
        else flag_error("rx ack or nak differs from model");
    a_rx_latency: assert property (@(posedge clk48_i) disable iff (rst_i)
        rx_end_i |=> (rx_ack_o || rx_nak_o))
        else flag_error("no rx handshake one cycle after rx_end_i");
    a_tx_latency: assert property (@(posedge clk48_i) disable iff (rst_i)
        (tx_req_i && !tx_busy) |=> (tx_valid_o || tx_nak_o))
        else flag_error("no tx answer one cycle after tx_req_i");
    a_tx_ctrl: assert property (@(posedge clk48_i) disable iff (rst_i)
        tx_valid_o == exp_tx_valid && tx_last_o == exp_tx_last && tx_nak_o == exp_tx_nak)
        else flag_error("tx valid, last or nak differs from model");
    a_tx_data: assert property (@(posedge clk48_i) disable iff (rst_i)
        tx_valid_o |-> tx_data_o == exp_tx_data)
        else flag_error("tx byte differs from model");

    task automatic send_rx_packet(input int ep, input int len, input logic crc_ok);
        rx_ep_i = ep_num_t'(ep);
        for (int i = 0; i < len; i++) begin
            rx_valid_i = 1'b1;
            rx_data_i  = byte_t'(rand_bits(8));
            @(negedge clk48_i);
        end
        rx_valid_i  = 1'b0;
        rx_end_i    = 1'b1;
        rx_crc_ok_i = crc_ok;
        @(negedge clk48_i);
        rx_end_i    = 1'b0;
        rx_crc_ok_i = 1'b0;
        while (!rx_ack_o && !rx_nak_o) @(negedge clk48_i);
        @(negedge clk48_i);
        trans_cnt++;
    endtask

    task automatic user_pop(input int k, input int n, input logic ok);
        repeat (n) begin
            ep_in_pop_data_i[k] = 1'b1;
            @(negedge clk48_i);
        end
        ep_in_pop_data_i[k]          = 1'b0;
        ep_in_pop_trans_done_i[k]    = 1'b1;
        ep_in_pop_trans_success_i[k] = ok;
        @(negedge clk48_i);
        ep_in_pop_trans_done_i[k]    = 1'b0;
        ep_in_pop_trans_success_i[k] = 1'b0;
        @(negedge clk48_i);
        trans_cnt++;
    endtask

    task automatic user_fill(input int k, input int n, input logic ok);
        repeat (n) begin
            ep_out_data_valid_i[k]     = 1'b1;
            ep_out_data_i[8*k +: 8]    = byte_t'(rand_bits(8));
            @(negedge clk48_i);
        end
        ep_out_data_valid_i[k]         = 1'b0;
        ep_out_fill_trans_done_i[k]    = 1'b1;
        ep_out_fill_trans_success_i[k] = ok;
        @(negedge clk48_i);
        ep_out_fill_trans_done_i[k]    = 1'b0;
        ep_out_fill_trans_success_i[k] = 1'b0;
        @(negedge clk48_i);
        trans_cnt++;
    endtask

    // The host answer goes out once the sequencer sits in TX_WAIT_HS
    task automatic tx_request(input int ep, input logic ack);
        tx_req_i = 1'b1;
        tx_ep_i  = ep_num_t'(ep);
        @(negedge clk48_i);
        tx_req_i = 1'b0;
        while (!tx_last_o && !tx_nak_o) @(negedge clk48_i);
        if (tx_last_o) begin
            @(negedge clk48_i);
            tx_ack_i  = ack;
            tx_fail_i = !ack;
            @(negedge clk48_i);
            tx_ack_i  = 1'b0;
            tx_fail_i = 1'b0;
        end
        @(negedge clk48_i);
        trans_cnt++;
    endtask

    always @(posedge clk48_i) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycle_cnt);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        int len [EP_COUNT];
        lfsr_q = 8'd37;
        error_cnt = 0;
        trans_cnt = 0;
        cycle_cnt = 0;
        rst_i = 1'b1;
        {rx_ep_i, rx_valid_i, rx_data_i, rx_end_i, rx_crc_ok_i} = '0;
        {tx_req_i, tx_ep_i, tx_ack_i, tx_fail_i} = '0;
        ep_in_pop_data_i            = '0;
        ep_in_pop_trans_done_i      = '0;
        ep_in_pop_trans_success_i   = '0;
        ep_out_data_valid_i         = '0;
        ep_out_fill_trans_done_i    = '0;
        ep_out_fill_trans_success_i = '0;
        ep_out_data_i               = '0;
        repeat (5) @(negedge clk48_i);
        rst_i = 1'b0;
        @(negedge clk48_i);

        // Good packets to every endpoint, then drained in order
        for (int k = 0; k < EP_COUNT; k++) begin
            len[k] = 1 + rand_bits(3);
            send_rx_packet(k + 1, len[k], 1'b1);
        end
        for (int k = 0; k < EP_COUNT; k++) user_pop(k, len[k], 1'b1);

        send_rx_packet(2, 5, 1'b0);
        send_rx_packet(0, 4, 1'b1);

        // Overflow refuses the second packet and keeps the first
        send_rx_packet(1, 10, 1'b1);
        send_rx_packet(1, 10, 1'b1);
        user_pop(0, 10, 1'b1);

        send_rx_packet(3, 6, 1'b1);
        user_pop(2, 4, 1'b0);
        user_pop(2, 6, 1'b1);

        user_fill(0, 11, 1'b1);
        tx_request(1, 1'b0);
        tx_request(1, 1'b1);
        tx_request(1, 1'b1);
        tx_request(1, 1'b1);
        tx_request(0, 1'b1);

        user_fill(1, 5, 1'b0);
        tx_request(2, 1'b1);
        user_fill(2, 16, 1'b0);
        tx_request(3, 1'b1);

        repeat (3) @(negedge clk48_i);
        $display("Transactions: %0d, errors: %0d", trans_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/usb_ep_pkg.sv
hw/ep_fifo_if.sv
hw/ep_fifo.sv
hw/ep_rx_router.sv
hw/ep_tx_sequencer.sv
hw/usb_ep_top.sv
test/tb_usb_ep_top.sv
